//--- rtl/fetch_geom_pkg.sv
package fetch_geom_pkg;

    // one instruction cache line
    localparam int LINE_BYTES = 16;
    localparam int LINE_OFF_W = $clog2(LINE_BYTES);

    // pc bits above the line offset
    localparam int LINE_ADDR_W = 28;

    // two adjacent lines come back per response
    localparam int LINES_W = 2 * LINE_BYTES * 8;

    // halfword positions in a fetch block, one output slot each
    localparam int SLOT_NUM = 8;
    localparam int COUNT_W = $clog2(SLOT_NUM + 1);

    // block size in halfwords, 1 to 8
    localparam int SIZE_W = 4;

    // byte offset of an instruction within its block
    localparam int OFFSET_W = 4;

    localparam int FTQ_IDX_W = 4;

    // output group buffer
    localparam int GROUP_DEPTH = 4;
    localparam int GROUP_PTR_W = $clog2(GROUP_DEPTH);

endpackage

//--- rtl/fetch_types_pkg.sv
package fetch_types_pkg;

    // risc-v exception code for a misaligned fetch
    localparam logic [3:0] EXC_INST_MISALIGNED = 4'd0;

    // fetch block handed over by the prediction queue
    typedef struct packed {
        logic [31:0]                           start_addr;
        logic [fetch_geom_pkg::SIZE_W-1:0]     block_size;
        logic [fetch_geom_pkg::FTQ_IDX_W-1:0]  ftq_idx;
    } fetch_req_t;

    // 32-bit window over the aligned lines
    // halves[0] is the lower parcel, low bits 2'b11 mean a 32-bit instruction
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] halves;
    } parcel_u;

    typedef struct packed {
        logic [31:0]                          inst;
        logic [fetch_geom_pkg::OFFSET_W-1:0]  offset;
    } slot_t;

    typedef struct packed {
        logic [31:0]                           inst;
        logic [fetch_geom_pkg::FTQ_IDX_W-1:0]  ftq_idx;
        logic [fetch_geom_pkg::OFFSET_W-1:0]   offset;
        logic                                  has_except;
        logic [3:0]                            except_code;
    } fetch_entry_t;

    // metadata following a request through s1 and s2
    typedef struct packed {
        logic [fetch_geom_pkg::FTQ_IDX_W-1:0]   ftq_idx;
        logic [fetch_geom_pkg::LINE_OFF_W-1:0]  shift;
        logic [fetch_geom_pkg::SIZE_W-1:0]      block_size;
        logic                                   misaligned;
        logic                                   valid;
    } track_t;

endpackage

//--- rtl/fetch_request_unit.sv
`timescale 1ns/10ps

module fetch_request_unit (
    input  logic                                     clk,
    input  logic                                     rst,

    input  logic                                     i_req_vld,
    input  fetch_types_pkg::fetch_req_t              i_req,
    output logic                                     o_req_taken,

    output logic                                     o_icache_req,
    output logic [fetch_geom_pkg::LINE_ADDR_W-1:0]   o_icache_addr,
    output logic                                     o_icache_get2,
    input  logic                                     i_icache_gnt,

    input  logic                                     i_space_ok,
    output logic                                     o_s1_vld,
    output fetch_types_pkg::track_t                  o_s2_track
);
    import fetch_geom_pkg::*;
    import fetch_types_pkg::*;

    logic   misaligned;
    logic   aligned_take;
    logic   misaligned_take;
    logic   accept;
    track_t s1_track;
    track_t s2_track;

    // odd pc never reaches the cache
    assign misaligned = i_req.start_addr[0];

    assign o_icache_req  = i_req_vld && !misaligned && i_space_ok;
    assign o_icache_addr = i_req.start_addr[31:LINE_OFF_W];

    // upper half start may spill into the next line
    assign o_icache_get2 = i_req.start_addr[LINE_OFF_W-1:0] >= LINE_BYTES / 2;

    assign aligned_take    = o_icache_req && i_icache_gnt;
    assign misaligned_take = i_req_vld && misaligned && i_space_ok;
    assign accept          = aligned_take || misaligned_take;
    assign o_req_taken     = accept;

    // s1 in the cycle after grant, s2 meets the response
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_track <= '0;
            s2_track <= '0;
        end else begin
            s1_track.valid      <= accept;
            s1_track.misaligned <= misaligned;
            s1_track.ftq_idx    <= i_req.ftq_idx;
            s1_track.shift      <= i_req.start_addr[LINE_OFF_W-1:0];
            s1_track.block_size <= i_req.block_size;
            s2_track            <= s1_track;
        end
    end

    assign o_s1_vld   = s1_track.valid;
    assign o_s2_track = s2_track;

endmodule

//--- rtl/parcel_decode.sv
`timescale 1ns/10ps

module parcel_decode (
    input  logic [fetch_geom_pkg::LINES_W-1:0]          i_lines,
    input  logic [fetch_geom_pkg::LINE_OFF_W-1:0]       i_shift,
    output logic [fetch_geom_pkg::SLOT_NUM-1:0]         o_start_mask,
    output logic [fetch_geom_pkg::SLOT_NUM-1:0][31:0]   o_parcels
);
    import fetch_geom_pkg::*;
    import fetch_types_pkg::*;

    logic [LINES_W-1:0]     merged;
    parcel_u [SLOT_NUM-1:0] window;
    logic [SLOT_NUM-1:0]    is_32b;

    // byte shift puts the block start at bit 0
    // an even shift of at most 14 bytes leaves room for all windows
    assign merged = i_lines >> {i_shift, 3'b000};

    always_comb begin
        for (int i = 0; i < SLOT_NUM; i++) begin
            window[i].word = merged[i*16 +: 32];
            is_32b[i]      = window[i].halves[0][1:0] == 2'b11;
            o_parcels[i]   = window[i].word;
        end
    end

    // boundary chain
    // a position is covered when a 32-bit instruction started just before it
    always_comb begin
        o_start_mask[0] = 1'b1;
        for (int i = 1; i < SLOT_NUM; i++) begin
            o_start_mask[i] = !(o_start_mask[i-1] && is_32b[i-1]);
        end
    end

endmodule

//--- rtl/slot_compactor.sv
`timescale 1ns/10ps

module slot_compactor (
    input  logic [fetch_geom_pkg::SLOT_NUM-1:0]                     i_start_mask,
    input  logic [fetch_geom_pkg::SLOT_NUM-1:0][31:0]               i_parcels,
    output fetch_types_pkg::slot_t [fetch_geom_pkg::SLOT_NUM-1:0]   o_slots,
    output logic [fetch_geom_pkg::COUNT_W-1:0]                      o_count
);
    import fetch_geom_pkg::*;

    // marked parcels move down in program order
    always_comb begin
        logic [COUNT_W-1:0] idx;
        idx     = '0;
        o_slots = '0;
        for (int i = 0; i < SLOT_NUM; i++) begin
            if (i_start_mask[i]) begin
                o_slots[idx].inst   = i_parcels[i];
                // halfword position to byte offset
                o_slots[idx].offset = OFFSET_W'(i * 2);
                idx                 = idx + 1'b1;
            end
        end
        o_count = idx;
    end

endmodule

//--- rtl/fetch_entry_builder.sv
`timescale 1ns/10ps

module fetch_entry_builder (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic                                                    i_icache_rsp,
    input  logic                                                    i_s1_vld,
    input  fetch_types_pkg::track_t                                 i_s2_track,
    input  fetch_types_pkg::slot_t [fetch_geom_pkg::SLOT_NUM-1:0]   i_slots,
    input  logic [fetch_geom_pkg::COUNT_W-1:0]                      i_count,
    input  logic                                                    i_backend_stall,
    output logic                                                    o_space_ok,
    output logic [fetch_geom_pkg::SLOT_NUM-1:0]                     o_fetch_vld,
    output fetch_types_pkg::fetch_entry_t [fetch_geom_pkg::SLOT_NUM-1:0] o_fetch_entry
);
    import fetch_geom_pkg::*;
    import fetch_types_pkg::*;

    logic [SLOT_NUM-1:0]                new_vld;
    fetch_entry_t [SLOT_NUM-1:0]        new_group;
    logic [SLOT_NUM-1:0]                vld_mem [GROUP_DEPTH];
    fetch_entry_t [SLOT_NUM-1:0]        grp_mem [GROUP_DEPTH];
    logic [GROUP_PTR_W-1:0]             wr_ptr;
    logic [GROUP_PTR_W-1:0]             rd_ptr;
    logic [GROUP_PTR_W:0]               grp_count;
    logic [GROUP_PTR_W:0]               used;
    logic                               push;
    logic                               pop;

    always_comb begin
        new_vld   = '0;
        new_group = '0;
        if (i_s2_track.misaligned) begin
            // single exception entry without instruction bits
            new_vld[0]               = 1'b1;
            new_group[0].ftq_idx     = i_s2_track.ftq_idx;
            new_group[0].has_except  = 1'b1;
            new_group[0].except_code = EXC_INST_MISALIGNED;
        end else begin
            for (int i = 0; i < SLOT_NUM; i++) begin
                // cut anything starting past the block end
                new_vld[i] = (COUNT_W'(i) < i_count) &&
                    ({1'b0, i_slots[i].offset} < {i_s2_track.block_size, 1'b0});
                new_group[i].inst    = i_slots[i].inst;
                new_group[i].ftq_idx = i_s2_track.ftq_idx;
                new_group[i].offset  = i_slots[i].offset;
            end
        end
    end

    assign push = i_s2_track.valid && (i_s2_track.misaligned || i_icache_rsp);
    assign pop  = (grp_count != '0) && !i_backend_stall;

    always_ff @(posedge clk) begin
        if (push) begin
            vld_mem[wr_ptr] <= new_vld;
            grp_mem[wr_ptr] <= new_group;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            grp_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            grp_count <= grp_count + push - pop;
        end
    end

    // buffered groups plus requests still in s1 or s2
    // no request is accepted while reset is held
    assign used = grp_count + (GROUP_PTR_W + 1)'(i_s1_vld)
                + (GROUP_PTR_W + 1)'(i_s2_track.valid);
    assign o_space_ok = !rst && (used < GROUP_DEPTH);

    assign o_fetch_vld   = (grp_count != '0) ? vld_mem[rd_ptr] : '0;
    assign o_fetch_entry = grp_mem[rd_ptr];

endmodule

//--- rtl/fetch_aligner.sv
`timescale 1ns/10ps

module fetch_aligner (
    input  logic                                                         clk,
    input  logic                                                         rst,

    // prediction queue side
    input  logic                                                         i_req_vld,
    input  fetch_types_pkg::fetch_req_t                                  i_req,
    output logic                                                         o_req_taken,

    // instruction cache side
    output logic                                                         o_icache_req,
    output logic [fetch_geom_pkg::LINE_ADDR_W-1:0]                       o_icache_addr,
    output logic                                                         o_icache_get2,
    input  logic                                                         i_icache_gnt,
    input  logic                                                         i_icache_rsp,
    input  logic [fetch_geom_pkg::LINES_W-1:0]                           i_icache_lines,

    // backend side
    input  logic                                                         i_backend_stall,
    output logic [fetch_geom_pkg::SLOT_NUM-1:0]                          o_fetch_vld,
    output fetch_types_pkg::fetch_entry_t [fetch_geom_pkg::SLOT_NUM-1:0] o_fetch_entry
);
    import fetch_geom_pkg::*;
    import fetch_types_pkg::*;

    track_t                     s2_track;
    logic                       s1_vld;
    logic                       space_ok;
    logic [SLOT_NUM-1:0]        start_mask;
    logic [SLOT_NUM-1:0][31:0]  parcels;
    slot_t [SLOT_NUM-1:0]       slots;
    logic [COUNT_W-1:0]         slot_count;

    fetch_request_unit u_request (
        .clk           (clk),
        .rst           (rst),
        .i_req_vld     (i_req_vld),
        .i_req         (i_req),
        .o_req_taken   (o_req_taken),
        .o_icache_req  (o_icache_req),
        .o_icache_addr (o_icache_addr),
        .o_icache_get2 (o_icache_get2),
        .i_icache_gnt  (i_icache_gnt),
        .i_space_ok    (space_ok),
        .o_s1_vld      (s1_vld),
        .o_s2_track    (s2_track)
    );

    parcel_decode u_decode (
        .i_lines      (i_icache_lines),
        .i_shift      (s2_track.shift),
        .o_start_mask (start_mask),
        .o_parcels    (parcels)
    );

    slot_compactor u_compact (
        .i_start_mask (start_mask),
        .i_parcels    (parcels),
        .o_slots      (slots),
        .o_count      (slot_count)
    );

    fetch_entry_builder u_builder (
        .clk             (clk),
        .rst             (rst),
        .i_icache_rsp    (i_icache_rsp),
        .i_s1_vld        (s1_vld),
        .i_s2_track      (s2_track),
        .i_slots         (slots),
        .i_count         (slot_count),
        .i_backend_stall (i_backend_stall),
        .o_space_ok      (space_ok),
        .o_fetch_vld     (o_fetch_vld),
        .o_fetch_entry   (o_fetch_entry)
    );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic o_clk,
    output logic o_rst
);

    // 4 ns period
    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

    // released after a fixed count of rising edges
    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

//--- verification/fetch_aligner_tb.sv
`timescale 1ns/10ps

module fetch_aligner_tb;
    import fetch_geom_pkg::*;
    import fetch_types_pkg::*;

    localparam int NUM_REQ      = 200;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLE_LIMIT  = NUM_REQ * 12 + RESET_CYCLES;
    localparam int MEM_HALVES   = 16 * 8;

    // expected group as the backend should see it
    typedef struct packed {
        logic [SLOT_NUM-1:0]          vld;
        fetch_entry_t [SLOT_NUM-1:0]  entry;
    } group_t;

    logic                           clk;
    logic                           rst;
    logic                           req_vld;
    fetch_req_t                     req;
    logic                           req_taken;
    logic                           icache_req;
    logic [LINE_ADDR_W-1:0]         icache_addr;
    logic                           icache_get2;
    logic                           icache_gnt = 1'b0;
    logic                           icache_rsp = 1'b0;
    logic [LINES_W-1:0]             icache_lines = '0;
    logic                           backend_stall = 1'b0;
    logic [SLOT_NUM-1:0]            fetch_vld;
    fetch_entry_t [SLOT_NUM-1:0]    fetch_entry;

    integer         seed = 85824;
    logic [15:0]    mem [MEM_HALVES];
    group_t         exp_q [$];
    int             value_errs = 0;
    int             other_errs = 0;
    int             groups_seen = 0;
    int             cycles;
    int             stall_left = 0;
    logic           started = 1'b0;
    logic           gnt_d1 = 1'b0;
    logic           gnt_d2 = 1'b0;
    logic [3:0]     line_d1 = '0;
    logic [3:0]     line_d2 = '0;

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clock (
        .o_clk (clk),
        .o_rst (rst)
    );

    fetch_aligner i_dut (
        .clk             (clk),
        .rst             (rst),
        .i_req_vld       (req_vld),
        .i_req           (req),
        .o_req_taken     (req_taken),
        .o_icache_req    (icache_req),
        .o_icache_addr   (icache_addr),
        .o_icache_get2   (icache_get2),
        .i_icache_gnt    (icache_gnt),
        .i_icache_rsp    (icache_rsp),
        .i_icache_lines  (icache_lines),
        .i_backend_stall (backend_stall),
        .o_fetch_vld     (fetch_vld),
        .o_fetch_entry   (fetch_entry)
    );

    // memory wraps every 16 lines
    function automatic logic [15:0] read_half(input logic [31:0] addr);
        return mem[addr[7:1]];
    endfunction

    // a line and the one above it
    function automatic logic [LINES_W-1:0] line_data(input logic [3:0] line);
        logic [LINES_W-1:0] d;
        logic [6:0]         base;
        base = {line, 3'b000};
        for (int h = 0; h < 16; h++) begin
            d[h*16 +: 16] = mem[base + 7'(h)];
        end
        return d;
    endfunction

    // walk halfwords from the block start under boundary and size rules
    function automatic group_t expected_group(input fetch_req_t r);
        group_t       g;
        int           pos;
        int           slot;
        logic [15:0]  lo;
        logic [15:0]  hi;
        logic [31:0]  pc;
        g    = '0;
        pos  = 0;
        slot = 0;
        if (r.start_addr[0]) begin
            g.vld[0]                = 1'b1;
            g.entry[0].ftq_idx      = r.ftq_idx;
            g.entry[0].has_except   = 1'b1;
            // misaligned pc code
            g.entry[0].except_code  = 4'd0;
        end else begin
            while (pos < int'(r.block_size)) begin
                pc = r.start_addr + 32'(2 * pos);
                lo = read_half(pc);
                hi = read_half(pc + 32'd2);
                g.vld[slot]           = 1'b1;
                g.entry[slot].inst    = {hi, lo};
                g.entry[slot].ftq_idx = r.ftq_idx;
                g.entry[slot].offset  = OFFSET_W'(2 * pos);
                slot = slot + 1;
                pos  = pos + ((lo[1:0] == 2'b11) ? 2 : 1);
            end
        end
        return g;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        assert (actv === expv) else begin
            value_errs++;
            $display("[ERROR] %s expected %h got %h", name, expv, actv);
        end
    endtask

    task automatic compare_group(input group_t g);
        check_value("o_fetch_vld", 32'(g.vld), 32'(fetch_vld));
        for (int i = 0; i < SLOT_NUM; i++) begin
            if (g.vld[i]) begin
                check_value($sformatf("o_fetch_entry[%0d].inst", i),
                            g.entry[i].inst, fetch_entry[i].inst);
                check_value($sformatf("o_fetch_entry[%0d].ftq_idx", i),
                            32'(g.entry[i].ftq_idx), 32'(fetch_entry[i].ftq_idx));
                check_value($sformatf("o_fetch_entry[%0d].offset", i),
                            32'(g.entry[i].offset), 32'(fetch_entry[i].offset));
                check_value($sformatf("o_fetch_entry[%0d].has_except", i),
                            32'(g.entry[i].has_except), 32'(fetch_entry[i].has_except));
                check_value($sformatf("o_fetch_entry[%0d].except_code", i),
                            32'(g.entry[i].except_code), 32'(fetch_entry[i].except_code));
            end
        end
    endtask

    // cache model with a two-cycle response after each grant
    always @(posedge clk) begin
        if (rst) begin
            gnt_d1 <= 1'b0;
            gnt_d2 <= 1'b0;
        end else begin
            gnt_d1  <= icache_req && icache_gnt;
            line_d1 <= icache_addr[3:0];
            gnt_d2  <= gnt_d1;
            line_d2 <= line_d1;
        end
    end

    always @(negedge clk) begin
        icache_gnt   = ($random(seed) & 3) != 0;
        icache_rsp   = gnt_d2;
        icache_lines = gnt_d2 ? line_data(line_d2) : '0;
    end

    // short random stalls with an occasional long stretch
    always @(negedge clk) begin
        if (stall_left != 0) begin
            stall_left--;
            backend_stall = 1'b1;
        end else if (($random(seed) & 63) == 0) begin
            stall_left    = 16 + ($random(seed) & 31);
            backend_stall = 1'b1;
        end else begin
            backend_stall = ($random(seed) & 3) == 0;
        end
    end

    // comparator and protocol checks
    always @(posedge clk) begin
        group_t exp_g;
        if (!rst) begin
            if (!started) begin
                assert (fetch_vld == '0 && !req_taken && !icache_req) else begin
                    other_errs++;
                    $display("outputs became active after reset before any request");
                end
            end
            assert (!(req_taken && exp_q.size() >= GROUP_DEPTH)) else begin
                other_errs++;
                $display("request taken while four groups were outstanding");
            end
            if (icache_req) begin
                assert (!req.start_addr[0]) else begin
                    other_errs++;
                    $display("cache request raised for an odd start address");
                end
            end
            if (icache_req && icache_gnt) begin
                check_value("o_icache_addr", 32'(req.start_addr[31:4]), 32'(icache_addr));
                check_value("o_icache_get2", 32'(req.start_addr[3:0] >= 4'd8),
                            32'(icache_get2));
            end
            if (fetch_vld != '0 && !backend_stall) begin
                assert (exp_q.size() != 0) else begin
                    other_errs++;
                    $display("group delivered with no request outstanding");
                end
                if (exp_q.size() != 0) begin
                    exp_g = exp_q.pop_front();
                    compare_group(exp_g);
                    groups_seen++;
                end
            end
            if (req_taken) begin
                exp_q.push_back(expected_group(req));
            end
        end
    end

    initial begin
        for (cycles = 0; cycles < CYCLE_LIMIT; cycles++) begin
            @(posedge clk);
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation FAILED");
        $finish;
    end

    // request source
    initial begin
        fetch_req_t r;
        req_vld = 1'b0;
        req     = '0;
        r       = '0;
        for (int i = 0; i < MEM_HALVES; i++) begin
            mem[i] = 16'($random(seed));
        end
        @(negedge clk);
        while (rst) @(negedge clk);
        repeat (4) @(negedge clk);
        for (int n = 0; n < NUM_REQ; n++) begin
            r.start_addr    = $random(seed);
            // about one in eight odd
            r.start_addr[0] = ($random(seed) & 7) == 0;
            r.block_size    = SIZE_W'(($random(seed) & 7) + 1);
            r.ftq_idx       = FTQ_IDX_W'(n);
            started = 1'b1;
            req     = r;
            req_vld = 1'b1;
            @(posedge clk);
            while (!req_taken) @(posedge clk);
            @(negedge clk);
            req_vld = 1'b0;
            if (($random(seed) & 3) == 0) begin
                @(negedge clk);
            end
        end
        while (exp_q.size() != 0) @(posedge clk);
        // catch any extra group
        repeat (20) @(posedge clk);
        assert (groups_seen == NUM_REQ) else begin
            other_errs++;
            $display("received %0d groups instead of %0d", groups_seen, NUM_REQ);
        end
        $display("groups checked: %0d, value errors: %0d, other errors: %0d",
                 groups_seen, value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- fetch_aligner.f
rtl/fetch_geom_pkg.sv
rtl/fetch_types_pkg.sv
rtl/fetch_request_unit.sv
rtl/parcel_decode.sv
rtl/slot_compactor.sv
rtl/fetch_entry_builder.sv
rtl/fetch_aligner.sv
verification/tb_clock_gen.sv
verification/fetch_aligner_tb.sv

//--- run_sim.sh
#!/bin/sh
# verilator build and run of the fetch aligner testbench

cd "$(dirname "$0")" || exit 1

TOP=fetch_aligner_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f fetch_aligner.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
    exit 0
fi

echo "pass message not found in $LOG"
exit 1
